/* any1Decoder.f */
+incdir+logic
logic/any1DecodePkg.sv
logic/decodeIf.sv
logic/regListPick.sv
logic/immGen.sv
logic/opcodeDecode.sv
logic/decodeStage.sv
logic/any1Decoder.sv
testbench/tbClock.sv
testbench/any1DecoderTb.sv

/* logic/any1DecodePkg.sv */
// Instruction, opcode and decode-word types shared by the decode stage and its testbench
`include "any1Decode_macros.svh"

package any1DecodePkg;

	typedef enum logic [7:0] {
		BRK   = 8'h00,
		R2    = 8'h02,
		ADDI  = 8'h04,
		MULI  = 8'h06,
		ANDI  = 8'h08,
		ORI   = 8'h09,
		XORI  = 8'h0A,
		SLTUI = 8'h0C,
		NOP   = 8'h3F,
		JAL   = 8'h40,
		BEQ   = 8'h48,
		BNE   = 8'h49,
		BLT   = 8'h4A,
		BGE   = 8'h4B,
		BLTU  = 8'h4C,
		BGEU  = 8'h4D,
		LDX   = 8'h60,
		STX   = 8'h68,
		C20   = 8'h70  // Compact group base, low nibble selects the form
	} Opcode;

	typedef enum logic [5:0] {
		ADD = 6'd0, SUB = 6'd1, AND = 6'd2, OR = 6'd3, XOR = 6'd4,
		SLL = 6'd5, SRL = 6'd6, MUL = 6'd8, DIV = 6'd9, SLTU = 6'd10
	} R2Func;

	typedef enum logic [3:0] {LDO = 4'd0, LSM = 4'd1} MemFunc;

	typedef enum logic [3:0] {
		NONE, SIGN16, ZERO16, ONES16, LOAD12, STORE12, BRANCH16, JUMP26, SCALED7, SIGN7
	} ImmFormat;

	// Three views of the same 36-bit word
	typedef struct packed {
		R2Func func;
		logic [3:0] pad;
		logic [`ANY1_REG_W-1:0] rb, ra, rt;
		Opcode opcode;
	} R2Insn;

	typedef struct packed {
		logic [15:0] imm16;
		logic [`ANY1_REG_W-1:0] ra, rt;
		Opcode opcode;
	} ImmInsn;

	typedef struct packed {
		MemFunc memFunc;
		logic [5:0] dispHi;  // Upper store displacement
		logic [`ANY1_REG_W-1:0] rb, ra, rt;
		Opcode opcode;
	} MemInsn;

	typedef union packed {
		R2Insn r2;
		ImmInsn ri;
		MemInsn mem;
	} Instruction;

	typedef struct packed {
		logic rfwr, needRa, needRb, mc, isSigned, branch, memOp, lsm, ui;
	} DecodeCtrl;

	typedef struct packed {
		DecodeCtrl ctrl;
		logic [`ANY1_REG_W-1:0] rt, ra, rb;
	} DecodeWord;

endpackage

/* logic/any1Decode_macros.svh */
// Widths and fixed register numbers for the decode stage, included wherever a width is needed
`ifndef ANY1_DECODE_MACROS_SVH
`define ANY1_DECODE_MACROS_SVH

// ====================
// Datapath widths
// ====================
`define ANY1_INSN_W 36   // Instruction word
`define ANY1_VALUE_W 64  // Immediate and value
`define ANY1_REG_W 6     // Register number
`define ANY1_LSM_W 36    // Load/store-multiple register list

// ====================
// Fixed registers
// ====================
`define ANY1_FP_REG 29   // Frame pointer
`define ANY1_SP_REG 30   // Stack pointer

`endif

/* logic/any1Decoder.sv */
// Top level of the registered decode stage, connecting the opcode decoder to the output register
`timescale 1ns/1ps
`include "any1Decode_macros.svh"

module any1Decoder (
	input logic clk,
	input logic rst,
	input logic inValid,
	output logic inReady,
	input any1DecodePkg::Instruction ir,
	input logic [`ANY1_LSM_W-1:0] lsmMask,
	output logic outValid,
	input logic outReady,
	output logic [`ANY1_REG_W-1:0] rt,
	output logic [`ANY1_REG_W-1:0] ra,
	output logic [`ANY1_REG_W-1:0] rb,
	output logic [`ANY1_VALUE_W-1:0] imm,
	output logic rfwr,
	output logic needRa,
	output logic needRb,
	output logic mc,
	output logic isSigned,
	output logic branch,
	output logic memOp,
	output logic lsm,
	output logic ui
);

	any1DecodePkg::DecodeWord outWord;

	decodeIf dIf ();

	opcodeDecode core (
		.ir(ir),
		.lsmMask(lsmMask),
		.inValid(inValid),
		.inReady(inReady),
		.dec(dIf.source)
	);

	decodeStage stage (
		.clk(clk),
		.rst(rst),
		.dec(dIf.sink),
		.outValid(outValid),
		.outReady(outReady),
		.word(outWord),
		.imm(imm)
	);

	// Registered word fanned out to flat ports
	assign rt = outWord.rt;
	assign ra = outWord.ra;
	assign rb = outWord.rb;
	assign rfwr = outWord.ctrl.rfwr;
	assign needRa = outWord.ctrl.needRa;
	assign needRb = outWord.ctrl.needRb;
	assign mc = outWord.ctrl.mc;
	assign isSigned = outWord.ctrl.isSigned;
	assign branch = outWord.ctrl.branch;
	assign memOp = outWord.ctrl.memOp;
	assign lsm = outWord.ctrl.lsm;
	assign ui = outWord.ctrl.ui;

endmodule

/* logic/decodeIf.sv */
// Handshake link that carries a decode word and its immediate from the decoder core to the output stage
`timescale 1ns/1ps
`include "any1Decode_macros.svh"

interface decodeIf;

	logic valid;                          // Decoder has a word
	any1DecodePkg::DecodeWord word;
	logic [`ANY1_VALUE_W-1:0] imm;        // Extended immediate from immGen
	logic ready;                          // Output stage can take it

	modport source (
		output valid,
		output word,
		output imm,
		input ready
	);

	modport sink (
		input valid,
		input word,
		input imm,
		output ready
	);

endinterface

/* logic/decodeStage.sv */
// Output register of the decode stage with a valid/ready handshake and back-pressure
`timescale 1ns/1ps
`include "any1Decode_macros.svh"

module decodeStage (
	input logic clk,
	input logic rst,
	decodeIf.sink dec,
	output logic outValid,
	input logic outReady,
	output any1DecodePkg::DecodeWord word,
	output logic [`ANY1_VALUE_W-1:0] imm
);

	logic load;

	// Take a new item when empty or when the current one leaves this cycle
	assign dec.ready = !outValid || outReady;
	assign load = dec.valid && dec.ready;

	// ====================
	// Control
	// ====================
	always_ff @(posedge clk) begin
		if (rst)
			outValid <= 1'b0;
		else if (dec.ready)
			outValid <= dec.valid;  // Drops to zero once drained
	end

	// ====================
	// Payload
	// ====================
	always_ff @(posedge clk) begin
		if (load) begin
			word <= dec.word;
			imm <= dec.imm;
		end
	end

	// A stalled item must not change under the consumer
	assert property (@(posedge clk) disable iff (rst)
		outValid && !outReady |=> outValid && $stable(word) && $stable(imm))
	else $error("Decode output changed while stalled");

endmodule

/* logic/immGen.sv */
// Builds the 64-bit immediate of an instruction for the format chosen by the opcode decode
`timescale 1ns/1ps
`include "any1Decode_macros.svh"

module immGen (
	input any1DecodePkg::Instruction ir,
	input any1DecodePkg::ImmFormat fmt,
	output logic [`ANY1_VALUE_W-1:0] imm
);

	localparam int VW = `ANY1_VALUE_W;

	always_comb begin
		unique case (fmt)
			any1DecodePkg::SIGN16:
				imm = {{VW-16{ir.ri.imm16[15]}}, ir.ri.imm16};
			any1DecodePkg::ZERO16:
				imm = {{VW-16{1'b0}}, ir.ri.imm16};
			any1DecodePkg::ONES16:
				imm = {{VW-16{1'b1}}, ir.ri.imm16};  // Keeps upper bits under AND
			any1DecodePkg::LOAD12:
				imm = {{VW-12{ir[31]}}, ir[31:20]};
			any1DecodePkg::STORE12:
				imm = {{VW-12{ir[31]}}, ir[31:26], ir[13:8]};  // Split around rb
			any1DecodePkg::BRANCH16:
				imm = {{VW-16{ir[35]}}, ir[35:26], ir[13:8]};
			any1DecodePkg::JUMP26:
				imm = {{VW-26{ir[35]}}, ir[35:10]};
			any1DecodePkg::SCALED7:
				imm = {{VW-10{ir[19]}}, ir[19:13], 3'b000};  // Word offset from FP or SP
			any1DecodePkg::SIGN7:
				imm = {{VW-7{ir[19]}}, ir[19:13]};
			default:
				imm = '0;
		endcase
	end

endmodule

/* logic/opcodeDecode.sv */
// Combinational opcode and function decode producing register numbers, control flags and immediate
`timescale 1ns/1ps
`include "any1Decode_macros.svh"

module opcodeDecode (
	input any1DecodePkg::Instruction ir,
	input logic [`ANY1_LSM_W-1:0] lsmMask,
	input logic inValid,
	output logic inReady,
	decodeIf.source dec
);

	any1DecodePkg::Opcode op;
	any1DecodePkg::R2Func func;
	any1DecodePkg::ImmFormat fmt;
	any1DecodePkg::DecodeWord word;
	logic [`ANY1_REG_W-1:0] rm;
	logic isLsm;

	assign op = ir.r2.opcode;
	assign func = ir.r2.func;
	assign isLsm = ir.mem.memFunc == any1DecodePkg::LSM;

	regListPick rlp (.lsmMask(lsmMask), .rm(rm));
	immGen ig (.ir(ir), .fmt(fmt), .imm(dec.imm));

	assign dec.valid = inValid;
	assign dec.word = word;
	assign inReady = dec.ready;  // Back-pressure straight from the output stage

	always_comb begin
		word = '0;
		word.ctrl.needRa = 1'b1;
		word.ctrl.isSigned = 1'b1;
		word.ctrl.ui = 1'b1;  // Cleared by every known form
		fmt = any1DecodePkg::NONE;

		// ====================
		// Compact 20-bit forms
		// ====================
		if (op[7:4] == 4'h7) begin
			case (op[3:0])
				4'd0, 4'd1: begin  // Scaled load from FP or SP
					word.ctrl.ui = 1'b0;
					if (op[0] || ir[12:8] != 5'd0) begin  // FP form with rt 0 is BRK
						word.rt = {1'b0, ir[12:8]};
						word.ra = `ANY1_REG_W'(op[0] ? `ANY1_SP_REG : `ANY1_FP_REG);
						word.ctrl.rfwr = 1'b1;
						fmt = any1DecodePkg::SCALED7;
					end
				end
				4'd2, 4'd3: begin  // Scaled store to FP or SP
					word.ctrl.ui = 1'b0;
					word.rb = {1'b0, ir[12:8]};
					word.ra = `ANY1_REG_W'(op[0] ? `ANY1_SP_REG : `ANY1_FP_REG);
					word.ctrl.needRb = 1'b1;
					fmt = any1DecodePkg::SCALED7;
				end
				4'd11: begin  // Load immediate
					word.ctrl.ui = 1'b0;
					word.rt = {1'b0, ir[12:8]};
					word.ctrl.rfwr = 1'b1;
					word.ctrl.needRa = 1'b0;
					fmt = any1DecodePkg::SIGN7;
				end
				default: ;
			endcase
		end else begin
			// ====================
			// Full-width forms
			// ====================
			case (op)
				any1DecodePkg::BRK, any1DecodePkg::NOP:
					word.ctrl.ui = 1'b0;
				any1DecodePkg::R2:
					case (func)
						any1DecodePkg::ADD, any1DecodePkg::SUB, any1DecodePkg::AND,
						any1DecodePkg::OR, any1DecodePkg::XOR, any1DecodePkg::SLL,
						any1DecodePkg::SRL, any1DecodePkg::MUL, any1DecodePkg::DIV,
						any1DecodePkg::SLTU: begin
							word.rt = ir.r2.rt;
							word.ra = ir.r2.ra;
							word.rb = ir.r2.rb;
							word.ctrl.rfwr = 1'b1;
							word.ctrl.needRb = 1'b1;
							word.ctrl.ui = 1'b0;
							word.ctrl.mc = func == any1DecodePkg::MUL || func == any1DecodePkg::DIV;
							word.ctrl.isSigned = func != any1DecodePkg::SLTU;
						end
						default: ;  // Unknown function stays unimplemented
					endcase
				any1DecodePkg::ADDI, any1DecodePkg::MULI, any1DecodePkg::ANDI,
				any1DecodePkg::ORI, any1DecodePkg::XORI, any1DecodePkg::SLTUI: begin
					word.rt = ir.ri.rt;
					word.ra = ir.ri.ra;
					word.ctrl.rfwr = 1'b1;
					word.ctrl.ui = 1'b0;
					word.ctrl.mc = op == any1DecodePkg::MULI;
					word.ctrl.isSigned = op != any1DecodePkg::SLTUI;
					if (op == any1DecodePkg::ANDI)
						fmt = any1DecodePkg::ONES16;
					else if (op == any1DecodePkg::ADDI || op == any1DecodePkg::MULI)
						fmt = any1DecodePkg::SIGN16;
					else
						fmt = any1DecodePkg::ZERO16;  // ORI, XORI, SLTUI
				end
				any1DecodePkg::BEQ, any1DecodePkg::BNE, any1DecodePkg::BLT,
				any1DecodePkg::BGE, any1DecodePkg::BLTU, any1DecodePkg::BGEU: begin
					word.ra = ir.r2.ra;
					word.rb = ir.r2.rb;
					word.ctrl.branch = 1'b1;
					word.ctrl.needRb = 1'b1;
					word.ctrl.mc = 1'b1;
					word.ctrl.ui = 1'b0;
					word.ctrl.isSigned = op != any1DecodePkg::BLTU && op != any1DecodePkg::BGEU;
					fmt = any1DecodePkg::BRANCH16;
				end
				any1DecodePkg::JAL: begin
					word.rt = {4'd0, ir[9:8]};  // Link register
					word.ctrl.rfwr = 1'b1;
					word.ctrl.mc = 1'b1;
					word.ctrl.needRa = 1'b0;
					word.ctrl.ui = 1'b0;
					fmt = any1DecodePkg::JUMP26;
				end
				any1DecodePkg::LDX: begin
					word.ra = ir.mem.ra;
					word.rt = isLsm ? rm : ir.mem.rt;
					word.ctrl.rfwr = 1'b1;
					word.ctrl.mc = 1'b1;
					word.ctrl.memOp = 1'b1;
					word.ctrl.lsm = isLsm;
					word.ctrl.ui = 1'b0;
					fmt = any1DecodePkg::LOAD12;
				end
				any1DecodePkg::STX: begin
					word.ra = ir.mem.ra;
					word.rb = isLsm ? rm : ir.mem.rb;
					word.ctrl.needRb = 1'b1;
					word.ctrl.mc = 1'b1;
					word.ctrl.memOp = 1'b1;
					word.ctrl.lsm = isLsm;
					word.ctrl.ui = 1'b0;
					fmt = any1DecodePkg::STORE12;
				end
				default: ;
			endcase
		end
	end

	// A memory op that reads rb is a store and never writes a register
	always_comb begin
		if (word.ctrl.memOp && word.ctrl.needRb)
			assert (!word.ctrl.rfwr)
			else $error("Store decoded with a register write");
	end

endmodule

/* logic/regListPick.sv */
// Finds the register for a load/store-multiple step from the lowest set bit of the register list
`timescale 1ns/1ps
`include "any1Decode_macros.svh"

module regListPick (
	input logic [`ANY1_LSM_W-1:0] lsmMask,
	output logic [`ANY1_REG_W-1:0] rm
);

	// Bits 2..7 are not in the list, bit 8 maps to register 3
	always_comb begin
		rm = '0;
		for (int n = `ANY1_LSM_W - 1; n >= 8; n--) begin
			if (lsmMask[n])
				rm = `ANY1_REG_W'(n - 5);  // Lower bits overwrite higher ones
		end
		if (lsmMask[1])
			rm = `ANY1_REG_W'(2);
		if (lsmMask[0])
			rm = `ANY1_REG_W'(1);
	end

	// Picked register maps back to a set list bit, zero only for an empty list
	always_comb begin
		if (rm == '0)
			assert (~|{lsmMask[`ANY1_LSM_W-1:8], lsmMask[1:0]})
			else $error("Register list has a member but none was picked");
		else
			assert (rm <= `ANY1_SP_REG && lsmMask[(rm <= 6'd2) ? rm - 6'd1 : rm + 6'd5])
			else $error("Picked register %0d is not in the list", rm);
	end

endmodule

/* run.sh */
#!/bin/sh
# Build and run the decode stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f any1Decoder.f --top-module any1DecoderTb -o simDecoder

./obj_dir/simDecoder > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q "TEST FAILED" sim.log; then
	exit 1
fi
exit 0

/* testbench/any1DecoderTb.sv */
// Randomized testbench for the registered decode stage, checking every output against a decode model
`timescale 1ns/1ps
`include "any1Decode_macros.svh"

module any1DecoderTb;

	localparam int TxPerTest = 400;
	localparam int TestCount = 5;
	localparam int CycleLimit = TxPerTest * TestCount * 4 + 200;  // 4 cycles per instruction
	localparam logic [7:0] AluOps [7] = '{8'h02, 8'h04, 8'h06, 8'h08, 8'h09, 8'h0A, 8'h0C};
	localparam logic [7:0] FlowOps [12] = '{8'h40, 8'h48, 8'h49, 8'h4A, 8'h4B, 8'h4C, 8'h4D,
		8'h70, 8'h71, 8'h72, 8'h73, 8'h7B};
	localparam logic [5:0] R2Funcs [10] = '{0, 1, 2, 3, 4, 5, 6, 8, 9, 10};

	typedef struct packed {
		logic [8:0] ctrl;  // rfwr needRa needRb mc isSigned branch memOp lsm ui
		logic [`ANY1_REG_W-1:0] rt, ra, rb;
		logic [`ANY1_VALUE_W-1:0] imm;
	} ExpectedDecode;

	logic clk, rst, inValid, inReady, outValid, outReady;
	logic [`ANY1_INSN_W-1:0] insn;
	logic [`ANY1_LSM_W-1:0] lsmMask;
	logic [`ANY1_REG_W-1:0] rt, ra, rb;
	logic [`ANY1_VALUE_W-1:0] imm;
	logic rfwr, needRa, needRb, mc, isSigned, branch, memOp, lsm, ui;
	ExpectedDecode pending[$];  // Accepted, not yet delivered
	int errors, accepted, transfers, cycles;
	bit acceptedLast;

	tbClock clkGen (.clk(clk));

	any1Decoder dut_i (
		.clk(clk), .rst(rst), .inValid(inValid), .inReady(inReady), .ir(insn),
		.lsmMask(lsmMask), .outValid(outValid), .outReady(outReady),
		.rt(rt), .ra(ra), .rb(rb), .imm(imm), .rfwr(rfwr), .needRa(needRa),
		.needRb(needRb), .mc(mc), .isSigned(isSigned), .branch(branch),
		.memOp(memOp), .lsm(lsm), .ui(ui)
	);

	// ====================
	// Reference decode
	// ====================
	function automatic logic [63:0] signExtend(input logic [63:0] v, input int w);
		logic [63:0] upper;
		upper = {64{1'b1}} << w;
		return v[w-1] ? (v | upper) : (v & ~upper);
	endfunction

	// Eligible bits 0, 1, 8..35 count as registers 1..30
	function automatic logic [5:0] listReg(input logic [35:0] mask);
		int bitPos;
		listReg = '0;
		for (int k = 1; k <= 30; k++) begin
			bitPos = (k <= 2) ? k - 1 : k + 5;
			if (mask[bitPos] && listReg == 0)
				listReg = 6'(k);
		end
	endfunction

	function automatic ExpectedDecode decodeModel(input logic [35:0] w, input logic [35:0] mask);
		ExpectedDecode e;
		logic fWr, fRa, fRb, fMc, fSgn, fBr, fMem, fLsm, fUi;
		logic [7:0] op;
		logic [5:0] fn;
		logic isList;
		e = '0;
		op = w[7:0];
		fn = w[35:30];
		isList = w[35:32] == 4'd1;
		{fWr, fRa, fRb, fMc, fSgn, fBr, fMem, fLsm, fUi} = 9'b0_1_0_0_1_0_0_0_1;
		if (op[7:4] == 4'h7) begin
			case (op[3:0])
				4'd0, 4'd1: begin
					fUi = 1'b0;
					if (op[0] || w[12:8] != 5'd0) begin  // FP form with rt 0 does nothing
						e.rt = {1'b0, w[12:8]};
						e.ra = op[0] ? 6'd30 : 6'd29;
						fWr = 1'b1;
						e.imm = signExtend({w[19:13], 3'b000}, 10);
					end
				end
				4'd2, 4'd3: begin
					fUi = 1'b0;
					e.rb = {1'b0, w[12:8]};
					e.ra = op[0] ? 6'd30 : 6'd29;
					fRb = 1'b1;
					e.imm = signExtend({w[19:13], 3'b000}, 10);
				end
				4'd11: begin
					fUi = 1'b0;
					e.rt = {1'b0, w[12:8]};
					fWr = 1'b1;
					fRa = 1'b0;
					e.imm = signExtend(w[19:13], 7);
				end
				default: ;
			endcase
		end else begin
			case (op)
				8'h00, 8'h3F: fUi = 1'b0;
				8'h02:
					if (fn <= 6'd10 && fn != 6'd7) begin
						{e.rt, e.ra, e.rb} = {w[13:8], w[19:14], w[25:20]};
						{fWr, fRb, fUi} = 3'b110;
						fMc = fn == 6'd8 || fn == 6'd9;
						fSgn = fn != 6'd10;
					end
				8'h04, 8'h06, 8'h08, 8'h09, 8'h0A, 8'h0C: begin
					{e.rt, e.ra} = {w[13:8], w[19:14]};
					{fWr, fUi} = 2'b10;
					fMc = op == 8'h06;
					fSgn = op != 8'h0C;
					if (op == 8'h08)
						e.imm = {48'hFFFF_FFFF_FFFF, w[35:20]};
					else if (op == 8'h04 || op == 8'h06)
						e.imm = signExtend(w[35:20], 16);
					else
						e.imm = {48'd0, w[35:20]};
				end
				8'h48, 8'h49, 8'h4A, 8'h4B, 8'h4C, 8'h4D: begin
					{e.ra, e.rb} = {w[19:14], w[25:20]};
					{fBr, fRb, fMc, fUi} = 4'b1110;
					fSgn = op != 8'h4C && op != 8'h4D;
					e.imm = signExtend({w[35:26], w[13:8]}, 16);
				end
				8'h40: begin
					e.rt = {4'd0, w[9:8]};  // Link register
					{fWr, fMc, fRa, fUi} = 4'b1100;
					e.imm = signExtend(w[35:10], 26);
				end
				8'h60: begin
					e.ra = w[19:14];
					e.rt = isList ? listReg(mask) : w[13:8];
					{fWr, fMc, fMem, fLsm, fUi} = {3'b111, isList, 1'b0};
					e.imm = signExtend(w[31:20], 12);
				end
				8'h68: begin
					e.ra = w[19:14];
					e.rb = isList ? listReg(mask) : w[25:20];
					{fRb, fMc, fMem, fLsm, fUi} = {3'b111, isList, 1'b0};
					e.imm = signExtend({w[31:26], w[13:8]}, 12);
				end
				default: ;
			endcase
		end
		e.ctrl = {fWr, fRa, fRb, fMc, fSgn, fBr, fMem, fLsm, fUi};
		return e;
	endfunction

	// ====================
	// Stimulus
	// ====================
	function automatic logic [7:0] pickOpcode(input int cls);
		int c;
		c = (cls > 3) ? int'($urandom % 4) : cls;  // Mixed test draws a class per instruction
		case (c)
			0: return AluOps[$urandom % 7];
			1: return FlowOps[$urandom % 12];
			2: return ($urandom % 2) ? 8'h60 : 8'h68;
			default: begin
				case ($urandom % 4)
					0: return 8'h3F;
					1: return 8'h00;
					2: return {4'h7, 4'($urandom)};  // Unlisted compact nibbles too
					default: return 8'($urandom);
				endcase
			end
		endcase
	endfunction

	task automatic driveInputs(input int cls, input bit heavyStall);
		logic [35:0] w;
		w = {4'($urandom), $urandom};
		w[7:0] = pickOpcode(cls);
		if (w[7:0] == 8'h02 && $urandom % 4 != 0)
			w[35:30] = R2Funcs[$urandom % 10];
		if (w[7:0] == 8'h60 || w[7:0] == 8'h68)
			w[35:32] = ($urandom % 4 < 2) ? 4'd1 : (($urandom % 2) ? 4'd0 : 4'($urandom));
		if (w[7:0] == 8'h70 && $urandom % 4 == 0)
			w[12:8] = '0;
		case ($urandom % 4)
			0: lsmMask = '0;
			1: lsmMask = {28'd0, 6'($urandom), 2'b00};  // Ineligible bits only
			2: lsmMask = 36'd1 << ($urandom % 36);
			default: lsmMask = {4'($urandom), $urandom};
		endcase
		insn = w;
		inValid = $urandom % 4 != 0;
		outReady = heavyStall ? ($urandom % 2 == 1) : ($urandom % 4 != 0);
	endtask

	// ====================
	// Checks
	// ====================
	task automatic checkValue(input string name, input logic [63:0] got, input logic [63:0] exp);
		assert (got === exp)
		else begin
			errors++;
			$display("** Error at %0t: %s got %h, expected %h", $time, name, got, exp);
		end
	endtask

	function automatic string flagName(input int i);
		case (i)
			0: return "rfwr";
			1: return "needRa";
			2: return "needRb";
			3: return "mc";
			4: return "isSigned";
			5: return "branch";
			6: return "memOp";
			7: return "lsm";
			default: return "ui";
		endcase
	endfunction

	task automatic compareOutputs(input ExpectedDecode e);
		logic [8:0] got;
		got = {rfwr, needRa, needRb, mc, isSigned, branch, memOp, lsm, ui};
		checkValue("rt", rt, e.rt);
		checkValue("ra", ra, e.ra);
		checkValue("rb", rb, e.rb);
		checkValue("imm", imm, e.imm);
		for (int i = 0; i < 9; i++)
			checkValue(flagName(i), got[8-i], e.ctrl[8-i]);
	endtask

	// Samples pre-edge values, the DUT updates only after this edge
	always @(posedge clk) begin : monitor
		if (!rst) begin
			checkValue("inReady", inReady, !outValid || outReady);
			if (acceptedLast)
				assert (outValid)
				else begin
					errors++;
					$display("Instruction accepted one cycle ago did not reach the outputs at %0t", $time);
				end
			assert (!outValid || pending.size() != 0)
			else begin
				errors++;
				$display("Output valid at %0t with no instruction outstanding", $time);
			end
			if (outValid && pending.size() != 0) begin
				compareOutputs(pending[0]);  // Held items are compared again each stall cycle
				if (outReady) begin
					void'(pending.pop_front());
					transfers++;
				end
			end else if (!outValid)
				assert (pending.size() == 0)
				else begin
					errors++;
					$display("Accepted instruction lost, output empty at %0t", $time);
				end
			acceptedLast = inValid && inReady;
			if (acceptedLast) begin
				pending.push_back(decodeModel(insn, lsmMask));
				accepted++;
			end
		end
	end

	always @(posedge clk) begin : watchdog
		cycles++;
		if (cycles > CycleLimit) begin
			$display("Timeout after %0d cycles, the instruction stream stopped moving", cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	task automatic runTest(input string name, input int cls, input bit heavyStall);
		int startErrors;
		int target;
		startErrors = errors;
		target = accepted + TxPerTest;
		while (accepted < target) begin
			driveInputs(cls, heavyStall);
			@(negedge clk);
		end
		inValid = 1'b0;
		outReady = 1'b1;  // Drain what is left
		while (outValid || pending.size() != 0)
			@(negedge clk);
		$display("Test %s: %0d instructions, %0d errors", name, TxPerTest, errors - startErrors);
	endtask

	initial begin
		void'($urandom(32'h81f4_592e));
		{errors, accepted, transfers, cycles} = '0;
		acceptedLast = 1'b0;
		rst = 1'b1;
		inValid = 1'b0;
		outReady = 1'b0;
		insn = '0;
		lsmMask = '0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		checkValue("outValid", outValid, 1'b0);
		checkValue("inReady", inReady, 1'b1);
		$display("Test resetState: %0d errors", errors);
		runTest("aluOps", 0, 1'b0);
		runTest("flowAndCompact", 1, 1'b0);
		runTest("memOps", 2, 1'b0);
		runTest("unimplemented", 3, 1'b0);
		runTest("mixedStalls", 4, 1'b1);
		$display("Summary: %0d accepted, %0d delivered, %0d errors", accepted, transfers, errors);
		if (errors == 0 && transfers == accepted)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

/* testbench/tbClock.sv */
// Free-running clock for the decode stage testbench, instantiated once by the testbench top
`timescale 1ns/1ps

module tbClock #(
	parameter real periodNs = 10.0
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever begin
			#(periodNs / 2.0) clk = ~clk;  // Half period per phase
		end
	end

endmodule
